//--- execPkg.sv
package execPkg;

    localparam int DataWidth = 16;   // Operand and result width
    localparam int AddrWidth = 16;   // PC, branch target and memory address width
    localparam int ShiftBits = 4;    // Low operandB bits used as shift amount

    // Instruction opcodes, 22 to 63 are unassigned and decode as illegal
    typedef enum logic [5:0] {
        OpLw1  = 6'd0,    // Load from operandA plus immediate
        OpLw2  = 6'd1,    // Load from operandA
        OpLw3  = 6'd2,    // Load immediate into register
        OpSw1  = 6'd3,    // Store to operandA plus immediate
        OpSw2  = 6'd4,    // Store to operandA
        OpMov  = 6'd5,
        OpAdd  = 6'd6,
        OpSub  = 6'd7,
        OpMul  = 6'd8,
        OpDiv  = 6'd9,
        OpAnd  = 6'd10,
        OpOr   = 6'd11,
        OpShl  = 6'd12,
        OpShr  = 6'd13,
        OpCmp  = 6'd14,   // Loads equal and less flags
        OpNot  = 6'd15,
        OpJr   = 6'd16,   // Jump to register
        OpJpc  = 6'd17,   // PC relative jump on less
        OpBrfl = 6'd18,   // Absolute branch on equal
        OpCall = 6'd19,
        OpRet  = 6'd20,
        OpNop  = 6'd21
    } opcodeE;

    // Branch condition selected by the decoder
    typedef enum logic [1:0] {
        CondAlways = 2'd0,
        CondLess   = 2'd1,
        CondEqual  = 2'd2
    } condE;

endpackage

//--- controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder
    import execPkg::*;
(
    input  opcodeE opcode,
    output logic   regWrite,
    output logic   memRead,
    output logic   memWrite,
    output logic   memToReg,
    output logic   branch,
    output logic   branchMode,    // 1 for absolute target, 0 for PC relative
    output condE   branchCond,
    output logic   stackPush,
    output logic   stackPop,
    output logic   isCompare,
    output logic   illegal
);

    always_comb begin
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memToReg   = 1'b0;
        branch     = 1'b0;
        branchMode = 1'b0;
        branchCond = CondAlways;
        stackPush  = 1'b0;
        stackPop   = 1'b0;
        isCompare  = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            OpLw1, OpLw2: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;         // Write-back comes from memory
            end
            OpLw3, OpMov, OpAdd, OpSub, OpMul, OpDiv,
            OpAnd, OpOr, OpShl, OpShr, OpNot: begin
                regWrite = 1'b1;
            end
            OpSw1, OpSw2: begin
                memWrite = 1'b1;
            end
            OpCmp: begin
                isCompare = 1'b1;
            end
            OpJr: begin
                branch     = 1'b1;
                branchMode = 1'b1;
            end
            OpJpc: begin
                branch     = 1'b1;
                branchCond = CondLess;   // Relative, mode stays 0
            end
            OpBrfl: begin
                branch     = 1'b1;
                branchMode = 1'b1;
                branchCond = CondEqual;  // Absolute target from immediate
            end
            OpCall: begin
                regWrite   = 1'b1;       // Link value pc plus 1
                branch     = 1'b1;
                branchMode = 1'b1;
                stackPush  = 1'b1;
            end
            OpRet: begin
                branch     = 1'b1;
                branchMode = 1'b1;
                stackPop   = 1'b1;
            end
            OpNop: begin
            end
            default: begin
                illegal = 1'b1;          // Sprite and video codes land here
            end
        endcase
    end

    // Stack traffic is one direction at a time
    stackExclusive: assert property (@(opcode) !(stackPush && stackPop));

endmodule

//--- aluCore.sv
`timescale 1ns/1ps

module aluCore
    import execPkg::*;
(
    input  opcodeE               opcode,
    input  logic [DataWidth-1:0] operandA,
    input  logic [DataWidth-1:0] operandB,
    input  logic [DataWidth-1:0] immediate,
    input  logic [AddrWidth-1:0] pc,
    output logic [DataWidth-1:0] aluResult,
    output logic [AddrWidth-1:0] memAddrRaw,
    output logic                 cmpEqual,
    output logic                 cmpLess
);

    logic [ShiftBits-1:0] shiftAmount;
    logic [AddrWidth-1:0] linkAddr;

    assign shiftAmount = operandB[ShiftBits-1:0];
    assign linkAddr    = pc + AddrWidth'(1);   // Return address for calls

    always_comb begin
        aluResult = '0;
        case (opcode)
            OpLw3: aluResult = immediate;
            OpMov: aluResult = operandB;
            OpAdd: aluResult = operandA + operandB;
            OpSub: aluResult = operandA - operandB;
            OpMul: aluResult = operandA * operandB;    // Low half of product
            OpDiv: begin
                if (operandB == '0) begin
                    aluResult = '1;                    // Divide by zero saturates
                end else begin
                    aluResult = operandA / operandB;
                end
            end
            OpAnd:  aluResult = operandA & operandB;
            OpOr:   aluResult = operandA | operandB;
            OpShl:  aluResult = operandA << shiftAmount;
            OpShr:  aluResult = operandA >> shiftAmount;
            OpNot:  aluResult = ~operandA;
            OpCall: aluResult = DataWidth'(linkAddr);
            default: aluResult = '0;
        endcase
    end

    // Offset addressing only for the first load and store forms
    always_comb begin
        case (opcode)
            OpLw1, OpSw1: memAddrRaw = AddrWidth'(operandA + immediate);
            default:      memAddrRaw = AddrWidth'(operandA);
        endcase
    end

    // Unsigned compare, flags are only kept for OpCmp
    assign cmpEqual = (operandA == operandB);
    assign cmpLess  = (operandA < operandB);

endmodule

//--- commitStage.sv
`timescale 1ns/1ps

module commitStage
    import execPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  logic                 regWrite,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic                 memToReg,
    input  logic                 branch,
    input  logic                 branchMode,
    input  condE                 branchCond,
    input  logic                 stackPush,
    input  logic                 stackPop,
    input  logic                 isCompare,
    input  logic                 illegal,
    input  logic [DataWidth-1:0] aluResult,
    input  logic [AddrWidth-1:0] memAddrRaw,
    input  logic                 cmpEqual,
    input  logic                 cmpLess,
    input  logic [DataWidth-1:0] operandA,
    input  logic [DataWidth-1:0] operandB,
    input  logic [DataWidth-1:0] immediate,
    input  logic [AddrWidth-1:0] pc,
    input  logic [AddrWidth-1:0] stackTop,
    output logic                 outValid,
    output logic                 regWriteEn,
    output logic                 writeFromMem,
    output logic [DataWidth-1:0] writeData,
    output logic                 memReadEn,
    output logic                 memWriteEn,
    output logic [AddrWidth-1:0] memAddr,
    output logic [DataWidth-1:0] memWriteData,
    output logic                 branchTaken,
    output logic [AddrWidth-1:0] branchTarget,
    output logic                 pushReturn,
    output logic                 popReturn,
    output logic                 illegalOp
);

    logic                 flagEqual;
    logic                 flagLess;
    logic                 condMet;
    logic [AddrWidth-1:0] target;

    // Condition sees flags from before this edge
    always_comb begin
        case (branchCond)
            CondAlways: condMet = 1'b1;
            CondLess:   condMet = flagLess;
            CondEqual:  condMet = flagEqual;
            default:    condMet = 1'b0;
        endcase
    end

    always_comb begin
        if (stackPop) begin
            target = stackTop;                                 // Return
        end else if (branchMode && branchCond == CondEqual) begin
            target = AddrWidth'(immediate);                    // OpBrfl
        end else if (branchMode) begin
            target = AddrWidth'(operandA);                     // Register jump or call
        end else begin
            target = pc + AddrWidth'(immediate);               // PC relative
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flagEqual    <= 1'b0;
            flagLess     <= 1'b0;
            outValid     <= 1'b0;
            regWriteEn   <= 1'b0;
            writeFromMem <= 1'b0;
            memReadEn    <= 1'b0;
            memWriteEn   <= 1'b0;
            branchTaken  <= 1'b0;
            pushReturn   <= 1'b0;
            popReturn    <= 1'b0;
            illegalOp    <= 1'b0;
        end else begin
            if (inValid && isCompare) begin
                flagEqual <= cmpEqual;
                flagLess  <= cmpLess;
            end
            outValid     <= inValid;
            regWriteEn   <= inValid && regWrite;
            writeFromMem <= inValid && memToReg;
            memReadEn    <= inValid && memRead;
            memWriteEn   <= inValid && memWrite;
            branchTaken  <= inValid && branch && condMet;      // Also the flush
            pushReturn   <= inValid && stackPush;
            popReturn    <= inValid && stackPop;
            illegalOp    <= inValid && illegal;
        end
    end

    // Data side holds its value through idle cycles
    always_ff @(posedge clk) begin
        if (inValid) begin
            writeData    <= aluResult;
            memAddr      <= memAddrRaw;
            memWriteData <= operandB;
            branchTarget <= target;
        end
    end

    memExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memReadEn && memWriteEn));
    popIsTaken: assert property (@(posedge clk) disable iff (!rstN)
        popReturn |-> branchTaken);

endmodule

//--- execStage.sv
`timescale 1ns/1ps

module execStage
    import execPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  opcodeE               opcode,
    input  logic [DataWidth-1:0] operandA,
    input  logic [DataWidth-1:0] operandB,
    input  logic [DataWidth-1:0] immediate,
    input  logic [AddrWidth-1:0] pc,
    input  logic [AddrWidth-1:0] stackTop,
    output logic                 outValid,
    output logic                 regWriteEn,
    output logic                 writeFromMem,
    output logic [DataWidth-1:0] writeData,
    output logic                 memReadEn,
    output logic                 memWriteEn,
    output logic [AddrWidth-1:0] memAddr,
    output logic [DataWidth-1:0] memWriteData,
    output logic                 branchTaken,
    output logic [AddrWidth-1:0] branchTarget,
    output logic                 pushReturn,
    output logic                 popReturn,
    output logic                 illegalOp
);

    logic                 regWrite;
    logic                 memRead;
    logic                 memWrite;
    logic                 memToReg;
    logic                 branch;
    logic                 branchMode;
    condE                 branchCond;
    logic                 stackPush;
    logic                 stackPop;
    logic                 isCompare;
    logic                 illegal;
    logic [DataWidth-1:0] aluResult;
    logic [AddrWidth-1:0] memAddrRaw;
    logic                 cmpEqual;
    logic                 cmpLess;

    controlDecoder controlDecoder_i (
        .opcode(opcode), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .memToReg(memToReg), .branch(branch), .branchMode(branchMode),
        .branchCond(branchCond), .stackPush(stackPush), .stackPop(stackPop),
        .isCompare(isCompare), .illegal(illegal)
    );

    aluCore aluCore_i (
        .opcode(opcode), .operandA(operandA), .operandB(operandB),
        .immediate(immediate), .pc(pc), .aluResult(aluResult),
        .memAddrRaw(memAddrRaw), .cmpEqual(cmpEqual), .cmpLess(cmpLess)
    );

    commitStage commitStage_i (
        .clk(clk), .rstN(rstN), .inValid(inValid),
        .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .memToReg(memToReg), .branch(branch), .branchMode(branchMode),
        .branchCond(branchCond), .stackPush(stackPush), .stackPop(stackPop),
        .isCompare(isCompare), .illegal(illegal),
        .aluResult(aluResult), .memAddrRaw(memAddrRaw),
        .cmpEqual(cmpEqual), .cmpLess(cmpLess),
        .operandA(operandA), .operandB(operandB), .immediate(immediate),
        .pc(pc), .stackTop(stackTop),
        .outValid(outValid), .regWriteEn(regWriteEn), .writeFromMem(writeFromMem),
        .writeData(writeData), .memReadEn(memReadEn), .memWriteEn(memWriteEn),
        .memAddr(memAddr), .memWriteData(memWriteData), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .pushReturn(pushReturn), .popReturn(popReturn),
        .illegalOp(illegalOp)
    );

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int PeriodNs    = 10,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic rstN
);

    logic clkReg = 1'b0;
    logic rstReg = 1'b0;    // Reset held from time zero

    assign clk  = clkReg;
    assign rstN = rstReg;

    always #(PeriodNs / 2) clkReg = ~clkReg;

    initial begin
        repeat (ResetCycles) @(posedge clkReg);
        @(negedge clkReg);
        rstReg = 1'b1;      // Released between sampling edges
    end

endmodule

//--- execStageTb.sv
`timescale 1ns/1ps

module execStageTb
    import execPkg::*;
();

    localparam int ResetCycles   = 2;
    localparam int NumDirected   = 20;
    localparam int NumRandom     = 2000;
    localparam int TimeoutCycles = (ResetCycles + NumDirected + NumRandom) * 11 / 10;
    localparam logic [31:0] LfsrSeed = 32'hb435b1d1;
    localparam logic [31:0] LfsrTaps = 32'h80200003;

    // Bit order matches the hex value in strobe mismatch lines, outValid is the MSB
    typedef struct packed {
        logic outValid, regWriteEn, writeFromMem, memReadEn, memWriteEn;
        logic branchTaken, pushReturn, popReturn, illegalOp;
    } strobeT;

    typedef struct packed {
        strobeT               s;
        logic                 wdKnown, maKnown, mwdKnown, btKnown;  // Fields the rules define
        logic [DataWidth-1:0] writeData;
        logic [AddrWidth-1:0] memAddr;
        logic [DataWidth-1:0] memWriteData;
        logic [AddrWidth-1:0] branchTarget;
    } expectT;

    logic                 clk;
    logic                 rstN;
    logic                 inValid;
    opcodeE               opcode;
    logic [DataWidth-1:0] operandA, operandB, immediate;
    logic [AddrWidth-1:0] pc, stackTop;
    logic                 outValid, regWriteEn, writeFromMem, memReadEn, memWriteEn;
    logic                 branchTaken, pushReturn, popReturn, illegalOp;
    logic [DataWidth-1:0] writeData, memWriteData;
    logic [AddrWidth-1:0] memAddr, branchTarget;
    strobeT               actualStrobes;

    int          cycleCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    logic [31:0] lfsrState  = LfsrSeed;
    logic        modelEqual = 1'b0;   // Model copy of the compare flags
    logic        modelLess  = 1'b0;
    expectT      heldData   = '0;     // Data outputs hold through idle cycles
    expectT      expQ[$];
    string       nameQ[$];
    int          dueQ[$];             // Cycle count at which each entry is checked

    tbClock #(.PeriodNs(10), .ResetCycles(ResetCycles)) tbClock_i (.clk(clk), .rstN(rstN));

    execStage execStage_i (.*);

    assign actualStrobes = {outValid, regWriteEn, writeFromMem, memReadEn, memWriteEn,
                            branchTaken, pushReturn, popReturn, illegalOp};

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LfsrTaps;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] randBits(input int count);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            r = {r[30:0], lfsrState[0]};   // One step per bit
        end
        return r;
    endfunction

    function automatic logic [DataWidth-1:0] expectedResult(input opcodeE op,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b,
            input logic [DataWidth-1:0] imm);
        case (op)
            OpLw3:   return imm;
            OpMov:   return b;
            OpAdd:   return a + b;
            OpSub:   return a - b;
            OpMul:   return a * b;
            OpDiv:   return (b == 0) ? '1 : a / b;   // All ones on divide by zero
            OpAnd:   return a & b;
            OpOr:    return a | b;
            OpShl:   return a << b[3:0];
            OpShr:   return a >> b[3:0];
            OpNot:   return ~a;
            default: return '0;
        endcase
    endfunction

    function automatic expectT referenceModel(input logic valid, input logic inReset,
            input opcodeE op, input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b,
            input logic [DataWidth-1:0] imm, input logic [AddrWidth-1:0] pcV,
            input logic [AddrWidth-1:0] st);
        expectT e;
        e = heldData;
        e.s = '0;
        if (valid) begin
            e.s.outValid = 1'b1;
            e.wdKnown    = 1'b0;
            e.maKnown    = 1'b0;
            e.mwdKnown   = 1'b0;
            e.btKnown    = 1'b0;
            case (op)
                OpLw1, OpLw2: begin
                    e.s.regWriteEn   = 1'b1;
                    e.s.memReadEn    = 1'b1;
                    e.s.writeFromMem = 1'b1;
                    e.maKnown        = 1'b1;
                    e.memAddr        = (op == OpLw1) ? a + imm : a;
                end
                OpSw1, OpSw2: begin
                    e.s.memWriteEn = 1'b1;
                    e.maKnown      = 1'b1;
                    e.memAddr      = (op == OpSw1) ? a + imm : a;
                    e.mwdKnown     = 1'b1;
                    e.memWriteData = b;
                end
                OpLw3, OpMov, OpAdd, OpSub, OpMul, OpDiv, OpAnd, OpOr, OpShl, OpShr, OpNot: begin
                    e.s.regWriteEn = 1'b1;
                    e.wdKnown      = 1'b1;
                    e.writeData    = expectedResult(op, a, b, imm);
                end
                OpCmp, OpNop: begin
                end
                OpJr: begin
                    e.s.branchTaken = 1'b1;
                    e.btKnown       = 1'b1;
                    e.branchTarget  = a;
                end
                OpJpc: begin
                    e.s.branchTaken = modelLess;      // Flags from before this edge
                    e.btKnown       = 1'b1;
                    e.branchTarget  = pcV + imm;
                end
                OpBrfl: begin
                    e.s.branchTaken = modelEqual;
                    e.btKnown       = 1'b1;
                    e.branchTarget  = imm;
                end
                OpCall: begin
                    e.s.regWriteEn  = 1'b1;
                    e.wdKnown       = 1'b1;
                    e.writeData     = pcV + 16'd1;    // Link value
                    e.s.branchTaken = 1'b1;
                    e.btKnown       = 1'b1;
                    e.branchTarget  = a;
                    e.s.pushReturn  = 1'b1;
                end
                OpRet: begin
                    e.s.branchTaken = 1'b1;
                    e.btKnown       = 1'b1;
                    e.branchTarget  = st;
                    e.s.popReturn   = 1'b1;
                end
                default: begin
                    e.s.illegalOp = 1'b1;
                end
            endcase
        end
        heldData = e;
        if (inReset) begin
            e.s        = '0;
            modelEqual = 1'b0;
            modelLess  = 1'b0;
        end else if (valid && op == OpCmp) begin
            modelEqual = (a == b);
            modelLess  = (a < b);
        end
        return e;
    endfunction

    task automatic compareValue(input string testName, input string field,
            input logic [15:0] expected, input logic [15:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("MISMATCH %s %s: expected %h, actual %h", testName, field, expected, actual);
        end
    endtask

    task automatic compareOutputs(input string testName, input expectT e);
        compareValue(testName, "strobes", {7'd0, e.s}, {7'd0, actualStrobes});
        if (e.wdKnown) begin
            compareValue(testName, "writeData", e.writeData, writeData);
        end
        if (e.maKnown) begin
            compareValue(testName, "memAddr", e.memAddr, memAddr);
        end
        if (e.mwdKnown) begin
            compareValue(testName, "memWriteData", e.memWriteData, memWriteData);
        end
        if (e.btKnown) begin
            compareValue(testName, "branchTarget", e.branchTarget, branchTarget);
        end
    endtask

    task automatic applyVector(input string testName, input logic valid, input opcodeE op,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b,
            input logic [DataWidth-1:0] imm, input logic [AddrWidth-1:0] pcV,
            input logic [AddrWidth-1:0] st);
        int due;
        @(negedge clk);
        due       = cycleCount + 1;   // Registered at the coming rising edge
        inValid   = valid;
        opcode    = op;
        operandA  = a;
        operandB  = b;
        immediate = imm;
        pc        = pcV;
        stackTop  = st;
        expQ.push_back(referenceModel(valid, due <= ResetCycles, op, a, b, imm, pcV, st));
        nameQ.push_back(testName);
        dueQ.push_back(due);
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        while (dueQ.size() != 0 && dueQ[0] == cycleCount) begin
            void'(dueQ.pop_front());
            compareOutputs(nameQ.pop_front(), expQ.pop_front());
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            errorCount++;
            $display("ERROR: run did not finish within %0d cycles", TimeoutCycles);
            $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        logic                 rValid;
        opcodeE               rOp;
        logic [DataWidth-1:0] rA;
        logic [DataWidth-1:0] rB;
        logic [DataWidth-1:0] rImm;
        logic [AddrWidth-1:0] rPc;
        logic [AddrWidth-1:0] rSt;
        int                   n;
        inValid   = 1'b0;
        opcode    = OpNop;
        operandA  = '0;
        operandB  = '0;
        immediate = '0;
        pc        = '0;
        stackTop  = '0;
        repeat (ResetCycles - 1) begin
            applyVector("inReset", 1'b0, OpNop, '0, '0, '0, '0, '0);
        end
        applyVector("afterReset", 1'b0, OpNop, '0, '0, '0, '0, '0);
        // Compare then conditional branch in the very next cycle
        applyVector("cmpLess", 1'b1, OpCmp, 16'd5, 16'd9, 16'h0, 16'h0, 16'h0);
        applyVector("jpcTaken", 1'b1, OpJpc, 16'h0, 16'h0, 16'h0010, 16'h0100, 16'h0);
        applyVector("brflNotTaken", 1'b1, OpBrfl, 16'h0, 16'h0, 16'h2000, 16'h0104, 16'h0);
        applyVector("cmpEqual", 1'b1, OpCmp, 16'd7, 16'd7, 16'h0, 16'h0, 16'h0);
        applyVector("jpcNotTaken", 1'b1, OpJpc, 16'h0, 16'h0, 16'hfff0, 16'h0200, 16'h0);
        applyVector("brflTaken", 1'b1, OpBrfl, 16'h0, 16'h0, 16'h2000, 16'h0204, 16'h0);
        applyVector("divZero", 1'b1, OpDiv, 16'h1234, 16'h0, 16'h0, 16'h0, 16'h0);
        applyVector("loadOffset", 1'b1, OpLw1, 16'h1000, 16'h0, 16'h0020, 16'h0, 16'h0);
        applyVector("loadDirect", 1'b1, OpLw2, 16'h2000, 16'h0, 16'h0020, 16'h0, 16'h0);
        applyVector("loadImm", 1'b1, OpLw3, 16'h0, 16'h0, 16'hbeef, 16'h0, 16'h0);
        applyVector("storeOffset", 1'b1, OpSw1, 16'h3000, 16'hcafe, 16'hffff, 16'h0, 16'h0);
        applyVector("storeDirect", 1'b1, OpSw2, 16'h4000, 16'h1111, 16'h0040, 16'h0, 16'h0);
        applyVector("jumpReg", 1'b1, OpJr, 16'h0abc, 16'h0, 16'h0, 16'h0, 16'h0);
        applyVector("call", 1'b1, OpCall, 16'h0400, 16'h0, 16'h0, 16'h0123, 16'h0);
        applyVector("ret", 1'b1, OpRet, 16'h0, 16'h0, 16'h0, 16'h0401, 16'h0124);
        applyVector("idleCall", 1'b0, OpCall, 16'h0800, 16'h0, 16'h0, 16'h0500, 16'h0);
        applyVector("illegal", 1'b1, opcodeE'(6'h3f), 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
        applyVector("nop", 1'b1, OpNop, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
        applyVector("illegalIdle", 1'b0, opcodeE'(6'h16), 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
        for (n = 0; n < NumRandom; n++) begin
            rValid = (randBits(3) != 0);   // Idle about one cycle in eight
            rOp    = opcodeE'(6'(randBits(6)));
            rA     = 16'(randBits(16));
            rB     = 16'(randBits(16));
            rImm   = 16'(randBits(16));
            rPc    = 16'(randBits(16));
            rSt    = 16'(randBits(16));
            applyVector("random", rValid, rOp, rA, rB, rImm, rPc, rSt);
        end
        while (dueQ.size() != 0) begin
            @(negedge clk);
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- flist.f
execPkg.sv
controlDecoder.sv
aluCore.sv
commitStage.sv
execStage.sv
tbClock.sv
execStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module execStageTb -f flist.f \
    && ./obj_dir/VexecStageTb | tee sim.log

grep -q "^Testbench passed$" sim.log \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL, see sim.log"; exit 1; }
